// ==== project.f ====
common/slink_axi_pkg.sv
common/slink_link_pkg.sv
design/slink_fifo.sv
channel/slink_channel.sv
router/slink_tx_router.sv
router/slink_rx_router.sv
design/slink_axi_top.sv
verification/slink_axi_chk.sv
verification/slink_axi_tb.sv

// ==== Makefile ====
# Verilator build and run for the AXI packet link bridge

VERILATOR ?= verilator
TOP       ?= slink_axi_tb
FILELIST  ?= project.f
BUILD     ?= obj_dir
LOG       ?= sim.log
SEED      ?= 1
VFLAGS    ?= --timing --assert

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1 || true
	@if grep -qF "** PASS **" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== verification/slink_axi_tb.sv ====
`timescale 1ns/1ns

module slink_axi_tb;

  localparam int clk_period   = 10;
  localparam int reset_cycles = 8;
  localparam int n_dir        = 4;    // beats per channel, one channel at a time
  localparam int n_mix        = 24;   // beats per channel, all channels at once
  localparam int n_tail       = 4;
  localparam int n_drop       = 3;
  localparam int n_txn        = slink_link_pkg::num_chan * (n_dir + n_mix + n_tail) + n_drop;

  typedef struct packed {
    logic [7:0]       id;
    logic [15:0]      cnt;
    logic [1:0][31:0] words;
  } ref_pkt_t;

  logic                          axi_clk;
  logic                          rst;
  logic                          tx_advance;
  logic                          full_speed;
  logic                          force_crc;
  logic                          force_bad_id;
  logic [31:0]                   rng;
  slink_link_pkg::link_tx_t      link_tx;
  slink_link_pkg::link_rx_t      link_rx;

  logic [63:0]                   drv_beat [slink_link_pkg::num_chan];
  logic [slink_link_pkg::num_chan-1:0] drv_valid;
  wire  [slink_link_pkg::num_chan-1:0] snd_rdy;
  logic [63:0]                   out_beat [slink_link_pkg::num_chan];
  wire  [slink_link_pkg::num_chan-1:0] out_valid;
  logic [slink_link_pkg::num_chan-1:0] out_ready;

  slink_axi_pkg::axi_addr_t      ini_aw;
  slink_axi_pkg::axi_addr_t      ini_ar;
  slink_axi_pkg::axi_wdata_t     ini_w;
  slink_axi_pkg::axi_bresp_t     tgt_b;
  slink_axi_pkg::axi_rdata_t     tgt_r;

  logic [63:0] link_q [slink_link_pkg::num_chan][$];   // sent, not yet on the link
  logic [63:0] exp_q  [slink_link_pkg::num_chan][$];   // sent, not yet out of the DUT
  ref_pkt_t    cur_pkt;
  int          pkt_left;
  int          word_idx;

  slink_axi_top i_dut (
    .axi_clk     (axi_clk),
    .rst         (rst),
    .tgt_aw      (drv_beat[slink_link_pkg::CH_AW][$bits(slink_axi_pkg::axi_addr_t)-1:0]),
    .tgt_awvalid (drv_valid[slink_link_pkg::CH_AW]),
    .tgt_awready (snd_rdy[slink_link_pkg::CH_AW]),
    .tgt_w       (drv_beat[slink_link_pkg::CH_W][$bits(slink_axi_pkg::axi_wdata_t)-1:0]),
    .tgt_wvalid  (drv_valid[slink_link_pkg::CH_W]),
    .tgt_wready  (snd_rdy[slink_link_pkg::CH_W]),
    .tgt_b       (tgt_b),
    .tgt_bvalid  (out_valid[slink_link_pkg::CH_B]),
    .tgt_bready  (out_ready[slink_link_pkg::CH_B]),
    .tgt_ar      (drv_beat[slink_link_pkg::CH_AR][$bits(slink_axi_pkg::axi_addr_t)-1:0]),
    .tgt_arvalid (drv_valid[slink_link_pkg::CH_AR]),
    .tgt_arready (snd_rdy[slink_link_pkg::CH_AR]),
    .tgt_r       (tgt_r),
    .tgt_rvalid  (out_valid[slink_link_pkg::CH_R]),
    .tgt_rready  (out_ready[slink_link_pkg::CH_R]),
    .ini_aw      (ini_aw),
    .ini_awvalid (out_valid[slink_link_pkg::CH_AW]),
    .ini_awready (out_ready[slink_link_pkg::CH_AW]),
    .ini_w       (ini_w),
    .ini_wvalid  (out_valid[slink_link_pkg::CH_W]),
    .ini_wready  (out_ready[slink_link_pkg::CH_W]),
    .ini_b       (drv_beat[slink_link_pkg::CH_B][$bits(slink_axi_pkg::axi_bresp_t)-1:0]),
    .ini_bvalid  (drv_valid[slink_link_pkg::CH_B]),
    .ini_bready  (snd_rdy[slink_link_pkg::CH_B]),
    .ini_ar      (ini_ar),
    .ini_arvalid (out_valid[slink_link_pkg::CH_AR]),
    .ini_arready (out_ready[slink_link_pkg::CH_AR]),
    .ini_r       (drv_beat[slink_link_pkg::CH_R][$bits(slink_axi_pkg::axi_rdata_t)-1:0]),
    .ini_rvalid  (drv_valid[slink_link_pkg::CH_R]),
    .ini_rready  (snd_rdy[slink_link_pkg::CH_R]),
    .link_tx     (link_tx),
    .tx_advance  (tx_advance),
    .link_rx     (link_rx)
  );

  bind slink_tx_router slink_axi_chk i_chk (
    .axi_clk    (axi_clk),
    .rst        (rst),
    .state      (state),
    .link_tx    (link_tx),
    .tx_advance (tx_advance),
    .word_take  (word_take)
  );

  always_comb begin
    out_beat[slink_link_pkg::CH_AW] = 64'(ini_aw);
    out_beat[slink_link_pkg::CH_W]  = 64'(ini_w);
    out_beat[slink_link_pkg::CH_B]  = 64'(tgt_b);
    out_beat[slink_link_pkg::CH_AR] = 64'(ini_ar);
    out_beat[slink_link_pkg::CH_R]  = 64'(tgt_r);
  end

  // loopback, a word counts on the cycle it is advanced
  always_comb begin
    link_rx.sop           = link_tx.sop;
    link_rx.data_id       = force_bad_id ? 8'hff : link_tx.data_id;
    link_rx.word_count    = link_tx.word_count;
    link_rx.app_data      = link_tx.app_data;
    link_rx.valid         = tx_advance;
    link_rx.crc_corrupted = force_crc;
  end

  initial begin
    axi_clk = 1'b0;
    forever #(clk_period / 2) axi_clk = ~axi_clk;
  end

  // ---------------------------------------------------------------------
  // helpers
  // ---------------------------------------------------------------------
  function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rng;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng = x;
    return x;
  endfunction

  function automatic int beat_width(input int ch);
    case (ch)
      slink_link_pkg::CH_W: return $bits(slink_axi_pkg::axi_wdata_t);
      slink_link_pkg::CH_B: return $bits(slink_axi_pkg::axi_bresp_t);
      slink_link_pkg::CH_R: return $bits(slink_axi_pkg::axi_rdata_t);
      default:              return $bits(slink_axi_pkg::axi_addr_t);
    endcase
  endfunction

  // expected packet: ids count up from 8'h20, low word first
  function automatic ref_pkt_t ref_packet(input int ch, input logic [63:0] beat);
    ref_pkt_t r;
    r.id       = 8'h20 + 8'(ch);
    r.cnt      = (beat_width(ch) > 32) ? 16'd2 : 16'd1;
    r.words[0] = beat[31:0];
    r.words[1] = beat[63:32];
    return r;
  endfunction

  function automatic int find_chan(input logic [7:0] id);
    ref_pkt_t r;
    int       hit;
    hit = -1;
    for (int ch = 0; ch < slink_link_pkg::num_chan; ch++) begin
      r = ref_packet(ch, '0);
      if (r.id == id) hit = ch;
    end
    return hit;
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "run stopped");
  endtask

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, exp));
    end
  endtask

  // ---------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------
  task automatic send_beats(input int ch, input int n, input bit keep);
    logic [63:0] beat;
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      r    = xorshift();
      beat = {xorshift(), xorshift()} & ((64'd1 << beat_width(ch)) - 64'd1);
      while (exp_q[ch].size() >= 3) @(negedge axi_clk);   // receive FIFO never overflows
      repeat (int'(r[1:0])) @(negedge axi_clk);
      drv_beat[ch]  = beat;
      drv_valid[ch] = 1'b1;
      @(posedge axi_clk);
      while (!snd_rdy[ch]) @(posedge axi_clk);
      link_q[ch].push_back(beat);
      if (keep) exp_q[ch].push_back(beat);
      @(negedge axi_clk);
      drv_valid[ch] = 1'b0;
    end
  endtask

  task automatic send_all(input int n);
    fork
      send_beats(slink_link_pkg::CH_AW, n, 1'b1);
      send_beats(slink_link_pkg::CH_W, n, 1'b1);
      send_beats(slink_link_pkg::CH_B, n, 1'b1);
      send_beats(slink_link_pkg::CH_AR, n, 1'b1);
      send_beats(slink_link_pkg::CH_R, n, 1'b1);
    join
  endtask

  task automatic wait_drained();
    int busy;
    busy = 1;
    while (busy != 0) begin
      @(negedge axi_clk);
      busy = pkt_left;
      for (int ch = 0; ch < slink_link_pkg::num_chan; ch++) begin
        busy = busy + exp_q[ch].size() + link_q[ch].size();
      end
    end
  endtask

  // one packet spoiled on the loopback, it must not come out
  task automatic drop_one(input int ch, input bit bad_id);
    wait_drained();
    force_crc    = !bad_id;
    force_bad_id = bad_id;
    send_beats(ch, 1, 1'b0);
    while (link_q[ch].size() != 0 || pkt_left != 0) @(negedge axi_clk);
    force_crc    = 1'b0;
    force_bad_id = 1'b0;
  endtask

  always @(negedge axi_clk) begin : link_drive
    logic [31:0] rnd;
    if (rst) begin
      tx_advance = 1'b0;
      out_ready  = '0;
    end else if (full_speed) begin
      tx_advance = 1'b1;
      out_ready  = '1;
    end else begin
      rnd        = xorshift();
      tx_advance = rnd[0] | rnd[1];
      out_ready  = rnd[6:2] | rnd[11:7];
    end
  end

  // ---------------------------------------------------------------------
  // monitors
  // ---------------------------------------------------------------------
  always @(posedge axi_clk) begin : link_mon
    int ch;
    if (!rst && tx_advance && (link_tx.sop || pkt_left != 0)) begin
      if (pkt_left == 0) begin
        ch = find_chan(link_tx.data_id);
        if (ch < 0) begin
          stop_run($sformatf("packet with unknown data id %h on the link", link_tx.data_id));
        end else if (link_q[ch].size() == 0) begin
          stop_run($sformatf("packet on the link for channel %0d with no beat sent", ch));
        end else begin
          cur_pkt  = ref_packet(ch, link_q[ch].pop_front());
          pkt_left = int'(cur_pkt.cnt);
          word_idx = 0;
          check_eq(64'(link_tx.word_count), 64'(cur_pkt.cnt), "link word count");
        end
      end
      if (pkt_left != 0) begin
        check_eq(64'(link_tx.sop), 64'(word_idx == 0), "link sop");
        check_eq(64'(link_tx.app_data), 64'(cur_pkt.words[word_idx[0]]), "link word");
        word_idx = word_idx + 1;
        pkt_left = pkt_left - 1;
      end
    end
  end

  always @(posedge axi_clk) begin : axi_mon
    logic [63:0] exp_beat;
    for (int ch = 0; ch < slink_link_pkg::num_chan; ch++) begin
      if (!rst && out_valid[ch] && out_ready[ch]) begin
        if (exp_q[ch].size() == 0) begin
          stop_run($sformatf("unexpected beat on the AXI output of channel %0d", ch));
        end else begin
          exp_beat = exp_q[ch].pop_front();
          check_eq(out_beat[ch], exp_beat, $sformatf("AXI beat on channel %0d", ch));
        end
      end
    end
  end

  initial begin : watchdog
    #((reset_cycles + 200 * n_txn) * clk_period);
    stop_run("timeout, the DUT stopped moving beats");
  end

  // ---------------------------------------------------------------------
  // test sequence
  // ---------------------------------------------------------------------
  initial begin
    rng          = 32'he44f;
    rst          = 1'b1;
    tx_advance   = 1'b0;
    out_ready    = '0;
    drv_valid    = '0;
    full_speed   = 1'b1;
    force_crc    = 1'b0;
    force_bad_id = 1'b0;
    pkt_left     = 0;
    word_idx     = 0;
    for (int ch = 0; ch < slink_link_pkg::num_chan; ch++) drv_beat[ch] = '0;
    repeat (reset_cycles) @(negedge axi_clk);
    rst = 1'b0;
    @(negedge axi_clk);
    check_eq(64'(link_tx.sop), 64'd0, "tx sop after reset");
    check_eq(64'(out_valid), 64'd0, "AXI valid outputs after reset");

    for (int ch = 0; ch < slink_link_pkg::num_chan; ch++) send_beats(ch, n_dir, 1'b1);
    wait_drained();

    full_speed = 1'b0;   // random stalls from here on
    send_all(n_mix);
    wait_drained();

    drop_one(slink_link_pkg::CH_W, 1'b0);
    drop_one(slink_link_pkg::CH_AR, 1'b1);
    drop_one(slink_link_pkg::CH_B, 1'b0);
    send_all(n_tail);
    wait_drained();

    if (i_dut.u_tx_router.i_chk.fail_cnt != 0) begin
      stop_run("assertion failures in the transmit router checker");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

// ==== verification/slink_axi_chk.sv ====
`timescale 1ns/1ns

module slink_axi_chk (
  input logic                                axi_clk,
  input logic                                rst,
  input slink_link_pkg::tx_state_e           state,
  input slink_link_pkg::link_tx_t            link_tx,
  input logic                                tx_advance,
  input logic [slink_link_pkg::num_chan-1:0] word_take
);

  int fail_cnt = 0;

  // ---------------------------------------------------------------------
  // link transmit port
  // ---------------------------------------------------------------------
  hold_word: assert property (@(posedge axi_clk) disable iff (rst)
    (state == slink_link_pkg::ST_SEND && !tx_advance) |=> $stable(link_tx))
    else begin
      $error("link_tx changed while tx_advance was low");
      fail_cnt++;
    end

  known_id: assert property (@(posedge axi_clk) disable iff (rst)
    link_tx.sop |-> (link_tx.data_id inside {[8'h20:8'h24]}))
    else begin
      $error("tx_sop with a data id outside the channel table");
      fail_cnt++;
    end

  // only the granted channel gives up a word
  one_take: assert property (@(posedge axi_clk) disable iff (rst)
    $onehot0(word_take))
    else begin
      $error("more than one word_take high");
      fail_cnt++;
    end

endmodule

// ==== design/slink_axi_top.sv ====
`timescale 1ns/1ns

module slink_axi_top (
  input  logic                      axi_clk,
  input  logic                      rst,
  // ---------------------------------------------------------------------
  // AXI target
  // ---------------------------------------------------------------------
  input  slink_axi_pkg::axi_addr_t  tgt_aw,
  input  logic                      tgt_awvalid,
  output logic                      tgt_awready,
  input  slink_axi_pkg::axi_wdata_t tgt_w,
  input  logic                      tgt_wvalid,
  output logic                      tgt_wready,
  output slink_axi_pkg::axi_bresp_t tgt_b,
  output logic                      tgt_bvalid,
  input  logic                      tgt_bready,
  input  slink_axi_pkg::axi_addr_t  tgt_ar,
  input  logic                      tgt_arvalid,
  output logic                      tgt_arready,
  output slink_axi_pkg::axi_rdata_t tgt_r,
  output logic                      tgt_rvalid,
  input  logic                      tgt_rready,
  // ---------------------------------------------------------------------
  // AXI initiator
  // ---------------------------------------------------------------------
  output slink_axi_pkg::axi_addr_t  ini_aw,
  output logic                      ini_awvalid,
  input  logic                      ini_awready,
  output slink_axi_pkg::axi_wdata_t ini_w,
  output logic                      ini_wvalid,
  input  logic                      ini_wready,
  input  slink_axi_pkg::axi_bresp_t ini_b,
  input  logic                      ini_bvalid,
  output logic                      ini_bready,
  output slink_axi_pkg::axi_addr_t  ini_ar,
  output logic                      ini_arvalid,
  input  logic                      ini_arready,
  input  slink_axi_pkg::axi_rdata_t ini_r,
  input  logic                      ini_rvalid,
  output logic                      ini_rready,
  // ---------------------------------------------------------------------
  // link
  // ---------------------------------------------------------------------
  output slink_link_pkg::link_tx_t  link_tx,
  input  logic                      tx_advance,
  input  slink_link_pkg::link_rx_t  link_rx
);

  slink_link_pkg::chan_payload_t snd_payload [slink_link_pkg::num_chan];
  slink_link_pkg::chan_payload_t rcv_payload [slink_link_pkg::num_chan];
  logic [slink_link_pkg::num_chan-1:0] snd_valid;
  logic [slink_link_pkg::num_chan-1:0] snd_ready;
  logic [slink_link_pkg::num_chan-1:0] rcv_valid;
  logic [slink_link_pkg::num_chan-1:0] rcv_ready;

  logic [slink_link_pkg::num_chan-1:0]                                  pkt_req;
  logic [slink_link_pkg::num_chan-1:0][slink_link_pkg::link_word_w-1:0] tx_word;
  logic [slink_link_pkg::num_chan-1:0]                                  word_take;
  logic [slink_link_pkg::num_chan-1:0]  rx_word_valid;
  logic                                 rx_sop;
  logic [slink_link_pkg::link_word_w-1:0] rx_app_data;
  logic                                 rx_crc_corrupted;

  // send side, beats zero extended into the payload
  always_comb begin
    snd_payload[slink_link_pkg::CH_AW] = slink_link_pkg::chan_payload_t'(tgt_aw);
    snd_payload[slink_link_pkg::CH_W]  = slink_link_pkg::chan_payload_t'(tgt_w);
    snd_payload[slink_link_pkg::CH_B]  = slink_link_pkg::chan_payload_t'(ini_b);
    snd_payload[slink_link_pkg::CH_AR] = slink_link_pkg::chan_payload_t'(tgt_ar);
    snd_payload[slink_link_pkg::CH_R]  = slink_link_pkg::chan_payload_t'(ini_r);
    snd_valid[slink_link_pkg::CH_AW]   = tgt_awvalid;
    snd_valid[slink_link_pkg::CH_W]    = tgt_wvalid;
    snd_valid[slink_link_pkg::CH_B]    = ini_bvalid;
    snd_valid[slink_link_pkg::CH_AR]   = tgt_arvalid;
    snd_valid[slink_link_pkg::CH_R]    = ini_rvalid;
    rcv_ready[slink_link_pkg::CH_AW]   = ini_awready;
    rcv_ready[slink_link_pkg::CH_W]    = ini_wready;
    rcv_ready[slink_link_pkg::CH_B]    = tgt_bready;
    rcv_ready[slink_link_pkg::CH_AR]   = ini_arready;
    rcv_ready[slink_link_pkg::CH_R]    = tgt_rready;
  end

  assign tgt_awready = snd_ready[slink_link_pkg::CH_AW];
  assign tgt_wready  = snd_ready[slink_link_pkg::CH_W];
  assign ini_bready  = snd_ready[slink_link_pkg::CH_B];
  assign tgt_arready = snd_ready[slink_link_pkg::CH_AR];
  assign ini_rready  = snd_ready[slink_link_pkg::CH_R];

  // receive side, payload cut back to the beat
  assign ini_aw = rcv_payload[slink_link_pkg::CH_AW][$bits(slink_axi_pkg::axi_addr_t)-1:0];
  assign ini_w  = rcv_payload[slink_link_pkg::CH_W][$bits(slink_axi_pkg::axi_wdata_t)-1:0];
  assign tgt_b  = rcv_payload[slink_link_pkg::CH_B][$bits(slink_axi_pkg::axi_bresp_t)-1:0];
  assign ini_ar = rcv_payload[slink_link_pkg::CH_AR][$bits(slink_axi_pkg::axi_addr_t)-1:0];
  assign tgt_r  = rcv_payload[slink_link_pkg::CH_R][$bits(slink_axi_pkg::axi_rdata_t)-1:0];

  assign ini_awvalid = rcv_valid[slink_link_pkg::CH_AW];
  assign ini_wvalid  = rcv_valid[slink_link_pkg::CH_W];
  assign tgt_bvalid  = rcv_valid[slink_link_pkg::CH_B];
  assign ini_arvalid = rcv_valid[slink_link_pkg::CH_AR];
  assign tgt_rvalid  = rcv_valid[slink_link_pkg::CH_R];

  // ---------------------------------------------------------------------
  // channels
  // ---------------------------------------------------------------------
  for (genvar i = 0; i < slink_link_pkg::num_chan; i++) begin : g_chan
    slink_channel #(
      .chan  (slink_link_pkg::link_chan_e'(i)),
      .depth (4)
    ) u_channel (
      .axi_clk       (axi_clk),
      .rst           (rst),
      .snd_payload   (snd_payload[i]),
      .snd_valid     (snd_valid[i]),
      .snd_ready     (snd_ready[i]),
      .pkt_req       (pkt_req[i]),
      .tx_word       (tx_word[i]),
      .word_take     (word_take[i]),
      .word_valid    (rx_word_valid[i]),
      .sop           (rx_sop),
      .app_data      (rx_app_data),
      .crc_corrupted (rx_crc_corrupted),
      .rcv_payload   (rcv_payload[i]),
      .rcv_valid     (rcv_valid[i]),
      .rcv_ready     (rcv_ready[i])
    );
  end

  // ---------------------------------------------------------------------
  // routing
  // ---------------------------------------------------------------------
  slink_tx_router u_tx_router (
    .axi_clk    (axi_clk),
    .rst        (rst),
    .pkt_req    (pkt_req),
    .tx_word    (tx_word),
    .word_take  (word_take),
    .link_tx    (link_tx),
    .tx_advance (tx_advance)
  );

  slink_rx_router u_rx_router (
    .axi_clk       (axi_clk),
    .rst           (rst),
    .link_rx       (link_rx),
    .word_valid    (rx_word_valid),
    .sop           (rx_sop),
    .app_data      (rx_app_data),
    .crc_corrupted (rx_crc_corrupted)
  );

endmodule

// ==== router/slink_rx_router.sv ====
`timescale 1ns/1ns

module slink_rx_router (
  input  logic                                   axi_clk,
  input  logic                                   rst,
  input  slink_link_pkg::link_rx_t               link_rx,
  output logic [slink_link_pkg::num_chan-1:0]    word_valid,
  output logic                                   sop,
  output logic [slink_link_pkg::link_word_w-1:0] app_data,
  output logic                                   crc_corrupted
);

  logic                       id_hit;
  slink_link_pkg::link_chan_e id_chan;
  slink_link_pkg::link_chan_e cur_chan;
  logic                       in_pkt;
  logic [15:0]                left;

  // id and length must both match the table
  always_comb begin
    id_hit  = 1'b0;
    id_chan = slink_link_pkg::CH_AW;
    for (int k = 0; k < slink_link_pkg::num_chan; k++) begin
      if (link_rx.data_id == slink_link_pkg::chan_data_id[k] &&
          link_rx.word_count == slink_link_pkg::chan_word_count[k]) begin
        id_hit  = 1'b1;
        id_chan = slink_link_pkg::link_chan_e'(k);
      end
    end
  end

  always_comb begin
    word_valid = '0;
    if (link_rx.valid) begin
      if (link_rx.sop) begin
        if (id_hit) begin
          word_valid[id_chan] = 1'b1;
        end
      end else if (in_pkt) begin
        word_valid[cur_chan] = 1'b1;   // rest of the packet
      end
    end
  end

  always_ff @(posedge axi_clk) begin
    if (rst) begin
      in_pkt   <= 1'b0;
      left     <= '0;
      cur_chan <= slink_link_pkg::CH_AW;
    end else if (link_rx.valid) begin
      if (link_rx.sop) begin
        in_pkt   <= id_hit && (link_rx.word_count > 16'd1);
        left     <= link_rx.word_count - 16'd1;
        cur_chan <= id_chan;
      end else if (in_pkt) begin
        left <= left - 16'd1;
        if (left == 16'd1) begin
          in_pkt <= 1'b0;
        end
      end
    end
  end

  // shared by all channels, word_valid picks the owner
  assign sop           = link_rx.sop;
  assign app_data      = link_rx.app_data;
  assign crc_corrupted = link_rx.crc_corrupted;

endmodule

// ==== router/slink_tx_router.sv ====
`timescale 1ns/1ns

module slink_tx_router (
  input  logic                                                              axi_clk,
  input  logic                                                              rst,
  input  logic [slink_link_pkg::num_chan-1:0]                               pkt_req,
  input  logic [slink_link_pkg::num_chan-1:0][slink_link_pkg::link_word_w-1:0] tx_word,
  output logic [slink_link_pkg::num_chan-1:0]                               word_take,
  output slink_link_pkg::link_tx_t                                          link_tx,
  input  logic                                                              tx_advance
);

  slink_link_pkg::tx_state_e  state;
  slink_link_pkg::link_chan_e grant;
  slink_link_pkg::link_chan_e nxt_chan;
  logic                       nxt_found;
  logic [15:0]                word_cnt;
  logic                       last_word;
  int                         rr_idx;

  // round robin, search starts after the last granted channel
  always_comb begin
    nxt_found = 1'b0;
    nxt_chan  = grant;
    rr_idx    = 0;
    for (int k = 1; k <= slink_link_pkg::num_chan; k++) begin
      rr_idx = (int'(grant) + k) % slink_link_pkg::num_chan;
      if (!nxt_found && pkt_req[rr_idx]) begin
        nxt_found = 1'b1;
        nxt_chan  = slink_link_pkg::link_chan_e'(rr_idx);
      end
    end
  end

  assign last_word = word_cnt == slink_link_pkg::chan_word_count[grant] - 16'd1;

  always_ff @(posedge axi_clk) begin
    if (rst) begin
      state    <= slink_link_pkg::ST_IDLE;
      grant    <= slink_link_pkg::CH_R;   // first search begins at CH_AW
      word_cnt <= '0;
    end else begin
      case (state)
        slink_link_pkg::ST_IDLE: begin
          if (nxt_found) begin
            grant    <= nxt_chan;
            word_cnt <= '0;
            state    <= slink_link_pkg::ST_SEND;
          end
        end
        slink_link_pkg::ST_SEND: begin
          if (tx_advance) begin
            if (last_word) begin
              state <= slink_link_pkg::ST_IDLE;   // release grant
            end else begin
              word_cnt <= word_cnt + 16'd1;
            end
          end
        end
        default: state <= slink_link_pkg::ST_IDLE;
      endcase
    end
  end

  // outputs come from registered state only, so they hold without tx_advance
  always_comb begin
    link_tx.sop        = (state == slink_link_pkg::ST_SEND) && (word_cnt == '0);
    link_tx.data_id    = slink_link_pkg::chan_data_id[grant];
    link_tx.word_count = slink_link_pkg::chan_word_count[grant];
    link_tx.app_data   = tx_word[grant];
  end

  always_comb begin
    word_take = '0;
    if (state == slink_link_pkg::ST_SEND && tx_advance) begin
      word_take[grant] = 1'b1;
    end
  end

endmodule

// ==== channel/slink_channel.sv ====
`timescale 1ns/1ns

module slink_channel #(
  parameter slink_link_pkg::link_chan_e chan = slink_link_pkg::CH_AW,
  parameter int                         depth = 4
) (
  input  logic                                      axi_clk,
  input  logic                                      rst,
  // send side
  input  slink_link_pkg::chan_payload_t             snd_payload,
  input  logic                                      snd_valid,
  output logic                                      snd_ready,
  // transmit router
  output logic                                      pkt_req,
  output logic [slink_link_pkg::link_word_w-1:0]    tx_word,
  input  logic                                      word_take,
  // receive router
  input  logic                                      word_valid,
  input  logic                                      sop,
  input  logic [slink_link_pkg::link_word_w-1:0]    app_data,
  input  logic                                      crc_corrupted,
  // receive side
  output slink_link_pkg::chan_payload_t             rcv_payload,
  output logic                                      rcv_valid,
  input  logic                                      rcv_ready
);

  slink_link_pkg::chan_payload_t snd_head;
  logic                          snd_full;
  logic                          snd_empty;
  logic                          snd_pop;
  logic [15:0]                   snd_idx;
  logic                          snd_last;

  slink_link_pkg::chan_payload_t asm_q;
  slink_link_pkg::chan_payload_t asm_next;
  logic [15:0]                   rcv_idx;
  logic [15:0]                   rcv_slot;
  logic                          rcv_last;
  logic                          rcv_push;
  logic                          rcv_full;
  logic                          rcv_empty;

  // ---------------------------------------------------------------------
  // send: buffer beats, hand out one link word at a time
  // ---------------------------------------------------------------------
  assign snd_ready = !snd_full;
  assign pkt_req   = !snd_empty;
  assign snd_last  = snd_idx == slink_link_pkg::chan_word_count[chan] - 16'd1;
  assign snd_pop   = word_take && snd_last;
  assign tx_word   = snd_head[snd_idx*slink_link_pkg::link_word_w +: slink_link_pkg::link_word_w];

  slink_fifo #(.depth(depth)) u_snd_fifo (
    .axi_clk (axi_clk),
    .rst     (rst),
    .wr_en   (snd_valid && snd_ready),
    .wr_data (snd_payload),
    .rd_en   (snd_pop),
    .rd_data (snd_head),
    .full    (snd_full),
    .empty   (snd_empty)
  );

  always_ff @(posedge axi_clk) begin
    if (rst) begin
      snd_idx <= '0;
    end else if (word_take) begin
      snd_idx <= snd_last ? '0 : snd_idx + 16'd1;
    end
  end

  // ---------------------------------------------------------------------
  // receive: collect words from sop, push the beat on the last one
  // ---------------------------------------------------------------------
  always_comb begin
    rcv_slot = sop ? '0 : rcv_idx;
    asm_next = sop ? '0 : asm_q;   // clear leftovers of a longer packet
    asm_next[rcv_slot*slink_link_pkg::link_word_w +: slink_link_pkg::link_word_w] = app_data;
  end

  assign rcv_last  = word_valid && (rcv_slot == slink_link_pkg::chan_word_count[chan] - 16'd1);
  assign rcv_push  = rcv_last && !crc_corrupted && !rcv_full;   // bad or overflowing packet dropped
  assign rcv_valid = !rcv_empty;

  always_ff @(posedge axi_clk) begin
    if (word_valid) begin
      asm_q <= asm_next;
    end
  end

  always_ff @(posedge axi_clk) begin
    if (rst) begin
      rcv_idx <= '0;
    end else if (word_valid) begin
      rcv_idx <= rcv_last ? '0 : rcv_slot + 16'd1;
    end
  end

  slink_fifo #(.depth(depth)) u_rcv_fifo (
    .axi_clk (axi_clk),
    .rst     (rst),
    .wr_en   (rcv_push),
    .wr_data (asm_next),
    .rd_en   (rcv_valid && rcv_ready),
    .rd_data (rcv_payload),
    .full    (rcv_full),
    .empty   (rcv_empty)
  );

endmodule

// ==== design/slink_fifo.sv ====
`timescale 1ns/1ns

module slink_fifo #(
  parameter int depth = 4
) (
  input  logic                          axi_clk,
  input  logic                          rst,
  input  logic                          wr_en,
  input  slink_link_pkg::chan_payload_t wr_data,
  input  logic                          rd_en,
  output slink_link_pkg::chan_payload_t rd_data,
  output logic                          full,
  output logic                          empty
);

  slink_link_pkg::chan_payload_t mem [depth];
  logic [$clog2(depth)-1:0]      wr_ptr;
  logic [$clog2(depth)-1:0]      rd_ptr;
  logic [$clog2(depth):0]        count;
  logic                          push;
  logic                          pop;

  assign push    = wr_en && !full;
  assign pop     = rd_en && !empty;
  assign full    = int'(count) == depth;
  assign empty   = count == '0;
  assign rd_data = mem[rd_ptr];   // head is visible without a read

  always_ff @(posedge axi_clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge axi_clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (int'(wr_ptr) == depth - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (int'(rd_ptr) == depth - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

// ==== common/slink_link_pkg.sv ====
package slink_link_pkg;

  localparam int link_word_w = 32;

  // channel order matches the payload arrays in the top
  typedef enum logic [2:0] {
    CH_AW,
    CH_W,
    CH_B,
    CH_AR,
    CH_R
  } link_chan_e;

  localparam int num_chan = 5;

  // fixed ids and packet lengths, indexed by link_chan_e
  localparam logic [0:num_chan-1][7:0] chan_data_id =
    {8'h20, 8'h21, 8'h22, 8'h23, 8'h24};
  localparam logic [0:num_chan-1][15:0] chan_word_count =
    {16'd2, 16'd2, 16'd1, 16'd2, 16'd2};

  typedef logic [63:0] chan_payload_t;   // axi beat, zero extended

  typedef struct packed {
    logic                   sop;
    logic [7:0]             data_id;
    logic [15:0]            word_count;
    logic [link_word_w-1:0] app_data;
  } link_tx_t;

  typedef struct packed {
    logic                   sop;
    logic [7:0]             data_id;
    logic [15:0]            word_count;
    logic [link_word_w-1:0] app_data;
    logic                   valid;
    logic                   crc_corrupted;   // meaningful on the last word
  } link_rx_t;

  typedef enum logic {
    ST_IDLE,
    ST_SEND
  } tx_state_e;

endpackage

// ==== common/slink_axi_pkg.sv ====
package slink_axi_pkg;

  localparam int axi_addr_w = 32;
  localparam int axi_data_w = 32;
  localparam int axi_id_w   = 8;

  // ---------------------------------------------------------------------
  // address channels, AW and AR use the same layout
  // ---------------------------------------------------------------------
  typedef struct packed {
    logic [axi_id_w-1:0]   id;
    logic [axi_addr_w-1:0] addr;
    logic [7:0]            len;
    logic [2:0]            size;
    logic [1:0]            burst;
  } axi_addr_t;

  // ---------------------------------------------------------------------
  // data and response channels
  // ---------------------------------------------------------------------
  typedef struct packed {
    logic [axi_id_w-1:0]     id;
    logic [axi_data_w-1:0]   data;
    logic [axi_data_w/8-1:0] strb;   // one bit per byte lane
    logic                    last;
  } axi_wdata_t;

  typedef struct packed {
    logic [axi_id_w-1:0] id;
    logic [1:0]          resp;
  } axi_bresp_t;

  typedef struct packed {
    logic [axi_id_w-1:0]   id;
    logic [axi_data_w-1:0] data;
    logic [1:0]            resp;
    logic                  last;
  } axi_rdata_t;

endpackage
